/* design/uart_defs.svh */
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// Serial bit timing

// Clock cycles per serial bit, overridden per instance
`define UART_CLKS_PER_BIT 16

// Identification

// Returned in bits 31:8 of a control register read
`define UART_ID_CODE 24'hA5_17_01

// Register map

// One address bit selects between the two registers
`define UART_ADDR_DATA 1'b0  // Tx write, status and rx byte read
`define UART_ADDR_CTRL 1'b1  // Interrupt enables, ID readback

`endif

/* design/uart_pkg.sv */
package uart_pkg;

  // One serial data byte
  typedef logic [7:0] uart_byte_t;

  // Bus write word, decoded by address
  typedef union packed {
    struct packed {
      logic [23:0] reserved;
      uart_byte_t  tx_data;    // Byte queued for transmission
    } data;                    // View at the data address
    struct packed {
      logic [29:0] reserved;
      logic        tx_irq_en;  // Enables interrupt[0]
      logic        rx_irq_en;  // Enables interrupt[1]
    } ctrl;                    // View at the control address
  } uart_wdata_u;

  // Read word at the data address
  typedef struct packed {
    logic [12:0] zero_hi;
    logic        overrun;     // Byte lost before it was read
    logic        rx_valid;    // Unread byte in rx_data
    logic        tx_pending;  // Byte waiting for the transmitter
    logic        tx_ready;    // Transmitter idle
    logic [6:0]  zero_lo;
    uart_byte_t  rx_data;
  } uart_status_t;

endpackage

/* design/uart_tx.sv */
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_tx #(
  parameter int unsigned clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                tx_start,
  input  uart_pkg::uart_byte_t tx_byte,
  output logic                tx_ready,
  output logic                tx
);

  localparam int unsigned cnt_w = $clog2(clks_per_bit + 1);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);

  logic             busy;
  logic [cnt_w-1:0] baud_cnt;   // Cycles within the current bit
  logic [3:0]       bit_idx;    // Start, 8 data, stop
  logic [9:0]       shift_q;    // Frame, LSB on the line

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      shift_q  <= '1;          // Line idles high
    end else if (tx_start) begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
      shift_q  <= {1'b1, tx_byte, 1'b0};
    end else if (busy) begin
      if (baud_cnt == last_cnt) begin
        baud_cnt <= '0;
        shift_q  <= {1'b1, shift_q[9:1]};  // Refill with idle level
        if (bit_idx == 4'd9) begin
          busy    <= 1'b0;     // Stop bit done
          bit_idx <= '0;
        end else begin
          bit_idx <= bit_idx + 4'd1;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  assign tx_ready = !busy;
  assign tx       = shift_q[0];

  // Start is only legal while idle
  a_start_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |-> tx_ready
  ) else $error("uart_tx: tx_start while busy");

endmodule

/* design/uart_rx.sv */
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_rx #(
  parameter int unsigned clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  output logic                 rx_done,
  output uart_pkg::uart_byte_t rx_byte
);

  import uart_pkg::*;

  localparam int unsigned cnt_w = $clog2(clks_per_bit + 1);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);
  localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clks_per_bit / 2 - 1);

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_start = 2'd1;
  localparam logic [1:0] st_data  = 2'd2;
  localparam logic [1:0] st_stop  = 2'd3;

  logic             rx_meta;
  logic             rx_sync;
  logic [1:0]       state;
  logic [cnt_w-1:0] baud_cnt;
  logic [2:0]       bit_idx;
  logic             done_q;
  uart_byte_t       data_q;    // Filled LSB first

  // Two-flop synchronizer, resets to idle level
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      baud_cnt <= '0;
      bit_idx  <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        st_idle: begin
          baud_cnt <= '0;
          bit_idx  <= '0;
          if (!rx_sync) state <= st_start;  // Falling edge of start bit
        end
        st_start: begin
          if (baud_cnt == half_cnt) begin
            baud_cnt <= '0;
            state    <= rx_sync ? st_idle : st_data;  // Glitch rejected
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        st_data: begin
          if (baud_cnt == last_cnt) begin
            baud_cnt <= '0;
            bit_idx  <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) state <= st_stop;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: begin
          if (baud_cnt == last_cnt) begin
            baud_cnt <= '0;
            done_q   <= rx_sync;   // Low stop bit drops the frame
            state    <= st_idle;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // Mid-bit data sampling
  always_ff @(posedge clk) begin
    if (state == st_data && baud_cnt == last_cnt) data_q <= {rx_sync, data_q[7:1]};
  end

  assign rx_done = done_q;
  assign rx_byte = data_q;

  a_done_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    rx_done |=> !rx_done
  ) else $error("uart_rx: rx_done longer than one cycle");

endmodule

/* design/uart_regs.sv */
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_regs (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 select,
  input  logic                 write,
  input  logic                 address,
  input  logic [3:0]           be,
  input  uart_pkg::uart_wdata_u data_in,
  output logic [31:0]          data_out,
  output logic [1:0]           interrupt,
  input  logic                 tx_ready,
  output logic                 tx_start,
  output uart_pkg::uart_byte_t tx_byte,
  input  logic                 rx_done,
  input  uart_pkg::uart_byte_t rx_byte
);

  import uart_pkg::*;

  logic         tx_pending;
  uart_byte_t   tx_hold;
  uart_byte_t   rx_hold;
  logic         rx_valid;
  logic         overrun;
  logic         tx_irq_en;
  logic         rx_irq_en;
  logic         wr_data;
  logic         wr_ctrl;
  logic         rd_data;
  uart_status_t status;
  logic [31:0]  ctrl_word;

  // Bus decode
  assign wr_data = select && write && (address == `UART_ADDR_DATA) && be[0];
  assign wr_ctrl = select && write && (address == `UART_ADDR_CTRL) && be[0];
  assign rd_data = select && !write && (address == `UART_ADDR_DATA);

  assign tx_start = tx_pending && tx_ready;
  assign tx_byte  = tx_hold;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_pending <= 1'b0;
      rx_valid   <= 1'b0;
      overrun    <= 1'b0;
      rx_hold    <= '0;
      tx_irq_en  <= 1'b0;
      rx_irq_en  <= 1'b0;
    end else begin
      if (wr_data && !tx_pending) begin
        tx_pending <= 1'b1;    // Writes while pending are dropped
      end else if (tx_start) begin
        tx_pending <= 1'b0;
      end

      if (rx_done) begin
        rx_valid <= 1'b1;
        rx_hold  <= rx_byte;
        overrun  <= !rd_data && (overrun || rx_valid);
      end else if (rd_data) begin
        rx_valid <= 1'b0;
        overrun  <= 1'b0;
      end

      if (wr_ctrl) begin
        tx_irq_en <= data_in.ctrl.tx_irq_en;
        rx_irq_en <= data_in.ctrl.rx_irq_en;
      end
    end
  end

  // Transmit holding register
  always_ff @(posedge clk) begin
    if (wr_data && !tx_pending) tx_hold <= data_in.data.tx_data;
  end

  always_comb begin
    status            = '0;
    status.overrun    = overrun;
    status.rx_valid   = rx_valid;
    status.tx_pending = tx_pending;
    status.tx_ready   = tx_ready;
    status.rx_data    = rx_hold;
  end

  assign ctrl_word = {`UART_ID_CODE, 6'b0, tx_irq_en, rx_irq_en};

  // Combinational read mux
  always_comb begin
    data_out = '0;
    if (select && !write) begin
      if (address == `UART_ADDR_DATA) data_out = status;
      else                            data_out = ctrl_word;
    end
  end

  assign interrupt = {rx_valid && rx_irq_en, tx_ready && tx_irq_en};

  // The transmitter takes the byte and goes busy on the next edge
  a_start_taken: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |=> !tx_ready
  ) else $error("uart_regs: transmitter did not accept tx_start");

endmodule

/* design/uart_periph.sv */
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_periph #(
  parameter int unsigned clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  select,
  input  logic                  write,
  input  logic                  address,
  input  logic [3:0]            be,
  input  uart_pkg::uart_wdata_u data_in,
  output logic [31:0]           data_out,
  output logic [1:0]            interrupt,
  input  logic                  rx,
  output logic                  tx
);

  import uart_pkg::*;

  logic       tx_ready;
  logic       tx_start;
  logic       rx_done;
  uart_byte_t tx_byte;
  uart_byte_t rx_byte;

  uart_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .select    (select),
    .write     (write),
    .address   (address),
    .be        (be),
    .data_in   (data_in),
    .data_out  (data_out),
    .interrupt (interrupt),
    .tx_ready  (tx_ready),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .rx_done   (rx_done),
    .rx_byte   (rx_byte)
  );

  uart_tx #(.clks_per_bit(clks_per_bit)) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_ready (tx_ready),
    .tx       (tx)
  );

  uart_rx #(.clks_per_bit(clks_per_bit)) u_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_done (rx_done),
    .rx_byte (rx_byte)
  );

endmodule

/* tb/uart_tb.sv */
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_tb;

  import uart_pkg::*;

  localparam int bit_cyc    = 8;            // Clocks per serial bit in the DUT
  localparam int bit_ns     = bit_cyc * 4;
  localparam int max_cycles = 6000;         // About 24 frames of 80 cycles plus bus traffic

  logic        clk;
  logic        rst_n;
  logic        select;
  logic        write;
  logic        address;
  logic [3:0]  be;
  uart_wdata_u data_in;
  logic [31:0] data_out;
  logic [1:0]  interrupt;
  logic        rx_drv;
  logic        loop_en;
  logic        rx_line;
  logic        tx;
  int          cycles;

  assign rx_line = loop_en ? tx : rx_drv;   // Loopback from tx to rx

  uart_periph #(.clks_per_bit(bit_cyc)) dut (
    .clk (clk), .rst_n (rst_n), .select (select), .write (write), .address (address),
    .be (be), .data_in (data_in), .data_out (data_out), .interrupt (interrupt),
    .rx (rx_line), .tx (tx)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", max_cycles);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic check_status(input uart_status_t got, input uart_status_t exp,
                              input bit with_data, input string what);
    if (!with_data) begin
      got.rx_data = '0;      // Held byte not known to the caller
      exp.rx_data = '0;
    end
    if (got !== exp) mismatch($sformatf("%s: status %h, expected %h", what, got, exp));
  endtask

  task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
    if (got !== exp) mismatch($sformatf("%s: byte %h, expected %h", what, got, exp));
  endtask

  task automatic check_irq(input logic [1:0] exp, input string what);
    if (interrupt !== exp) begin
      mismatch($sformatf("%s: interrupt %b, expected %b", what, interrupt, exp));
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) mismatch($sformatf("%s: word %h, expected %h", what, got, exp));
  endtask

  task automatic check_line(input logic got, input logic exp, input string what);
    if (got !== exp) mismatch($sformatf("%s: tx line %b, expected %b", what, got, exp));
  endtask

  // Status word as laid out in the register map
  function automatic uart_status_t make_status(input logic ovr, input logic rxv,
                                               input logic txp, input logic txr,
                                               input uart_byte_t d);
    uart_status_t s;
    s            = '0;
    s.overrun    = ovr;
    s.rx_valid   = rxv;
    s.tx_pending = txp;
    s.tx_ready   = txr;
    s.rx_data    = d;
    return s;
  endfunction

  task automatic bus_write(input logic a, input logic [3:0] b, input uart_wdata_u w);
    @(posedge clk);
    #1;
    select  = 1'b1;
    write   = 1'b1;
    address = a;
    be      = b;
    data_in = w;
    @(posedge clk);
    #1;
    select  = 1'b0;
    write   = 1'b0;
  endtask

  task automatic bus_read(input logic a, output logic [31:0] d);
    @(posedge clk);
    #1;
    select  = 1'b1;
    write   = 1'b0;
    address = a;
    be      = 4'hf;
    #1 d = data_out;         // Combinational read path
    @(posedge clk);
    #1;
    select  = 1'b0;
  endtask

  task automatic wait_rx(output uart_status_t s);
    logic [31:0] rd;
    do begin
      bus_read(`UART_ADDR_DATA, rd);
      s = rd;
    end while (!s.rx_valid);
  endtask

  // Start, 8 data bits LSB first, stop, then one idle bit
  task automatic send_serial(input uart_byte_t b, input logic stop);
    logic [9:0] frame;
    int i;
    frame = {stop, b, 1'b0};
    @(posedge clk);
    for (i = 0; i < 10; i++) begin
      #1 rx_drv = frame[i];
      repeat (bit_cyc) @(posedge clk);
    end
    #1 rx_drv = 1'b1;
    repeat (bit_cyc) @(posedge clk);
  endtask

  task automatic recv_serial(output uart_byte_t b);
    int i;
    @(negedge tx);
    #(bit_ns / 2 + 2);       // Mid bit, clear of the clock edge
    check_line(tx, 1'b0, "start bit");
    for (i = 0; i < 8; i++) begin
      #(bit_ns);
      b[i] = tx;
    end
    #(bit_ns);
    check_line(tx, 1'b1, "stop bit");
  endtask

  task automatic expect_line_idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1 check_line(tx, 1'b1, "idle line");
    end
  endtask

  task automatic reset_and_id();
    logic [31:0] rd;
    uart_wdata_u w;
    check_line(tx, 1'b1, "after reset");
    check_irq(2'b00, "after reset");
    bus_read(`UART_ADDR_DATA, rd);
    check_status(rd, make_status(0, 0, 0, 1, 8'h00), 1'b1, "after reset");
    bus_read(`UART_ADDR_CTRL, rd);
    check_word(rd, {`UART_ID_CODE, 8'h00}, "id read");
    w = '0;
    w.ctrl.tx_irq_en = 1'b1;
    w.ctrl.rx_irq_en = 1'b1;
    bus_write(`UART_ADDR_CTRL, 4'h1, w);
    bus_read(`UART_ADDR_CTRL, rd);
    check_word(rd, {`UART_ID_CODE, 8'h03}, "enables read back");
    check_irq(2'b01, "idle transmitter");
  endtask

  task automatic transmit_path();
    uart_wdata_u w;
    uart_byte_t  b0;
    uart_byte_t  b1;
    uart_byte_t  got;
    logic [31:0] rd;
    repeat (3) begin
      b0 = $urandom;
      w  = $urandom;         // Reserved bits are don't care
      w.data.tx_data = b0;
      bus_write(`UART_ADDR_DATA, 4'h1, w);
      recv_serial(got);
      check_byte(got, b0, "tx byte");
    end
    expect_line_idle(bit_cyc);              // Let the last frame finish
    b0 = $urandom;
    b1 = $urandom;
    w.data.tx_data = b0;
    bus_write(`UART_ADDR_DATA, 4'h1, w);
    fork
      recv_serial(got);
      begin
        w.data.tx_data = b1;
        bus_write(`UART_ADDR_DATA, 4'h1, w);   // Held while b0 is on the line
        w.data.tx_data = ~b1;
        bus_write(`UART_ADDR_DATA, 4'h1, w);   // Dropped
        bus_read(`UART_ADDR_DATA, rd);
        check_status(rd, make_status(0, 0, 1, 0, 8'h00), 1'b1, "pending");
        check_irq(2'b00, "transmitter busy");
      end
    join
    check_byte(got, b0, "first byte");
    recv_serial(got);
    check_byte(got, b1, "held byte");
    expect_line_idle(3 * bit_cyc);
    w.data.tx_data = $urandom;
    bus_write(`UART_ADDR_DATA, 4'b1110, w);
    expect_line_idle(3 * bit_cyc);
    bus_read(`UART_ADDR_DATA, rd);
    check_status(rd, make_status(0, 0, 0, 1, 8'h00), 1'b1, "no be[0]");
  endtask

  task automatic receive_path();
    uart_wdata_u  w;
    uart_byte_t   b;
    uart_status_t s;
    logic [31:0]  rd;
    int           en;
    for (en = 1; en >= 0; en--) begin
      w = '0;
      w.ctrl.rx_irq_en = en[0];
      bus_write(`UART_ADDR_CTRL, 4'h1, w);
      b = $urandom;
      send_serial(b, 1'b1);
      check_irq({en[0], 1'b0}, "rx interrupt");
      wait_rx(s);
      check_status(s, make_status(0, 1, 0, 1, b), 1'b1, "rx byte");
      bus_read(`UART_ADDR_DATA, rd);
      check_status(rd, make_status(0, 0, 0, 1, b), 1'b1, "after read");
      check_irq(2'b00, "after read");
    end
  endtask

  task automatic overrun_flag();
    uart_byte_t   a;
    uart_byte_t   b;
    uart_status_t s;
    logic [31:0]  rd;
    a = $urandom;
    b = $urandom;
    send_serial(a, 1'b1);
    send_serial(b, 1'b1);
    wait_rx(s);
    check_status(s, make_status(1, 1, 0, 1, b), 1'b1, "overrun");
    bus_read(`UART_ADDR_DATA, rd);
    check_status(rd, make_status(0, 0, 0, 1, b), 1'b1, "overrun cleared");
  endtask

  task automatic framing_error();
    uart_byte_t   b;
    uart_status_t s;
    logic [31:0]  rd;
    send_serial($urandom, 1'b0);   // Low stop bit
    bus_read(`UART_ADDR_DATA, rd);
    check_status(rd, make_status(0, 0, 0, 1, 8'h00), 1'b0, "bad frame");
    b = $urandom;
    send_serial(b, 1'b1);
    wait_rx(s);
    check_status(s, make_status(0, 1, 0, 1, b), 1'b1, "frame after bad one");
  endtask

  task automatic loopback_bytes();
    uart_wdata_u  w;
    uart_byte_t   b;
    uart_byte_t   got;
    uart_status_t s;
    @(posedge clk);
    #1 loop_en = 1'b1;
    repeat (8) begin
      b = $urandom;
      w = '0;
      w.data.tx_data = b;
      bus_write(`UART_ADDR_DATA, 4'h1, w);
      recv_serial(got);
      check_byte(got, b, "loopback line");
      repeat (bit_cyc) @(posedge clk);    // Past the stop bit
      wait_rx(s);
      check_status(s, make_status(0, 1, 0, 1, b), 1'b1, "loopback rx");
    end
    #1 loop_en = 1'b0;
  endtask

  initial begin
    void'($urandom(40583));
    cycles  = 0;
    rst_n   = 1'b0;
    select  = 1'b0;
    write   = 1'b0;
    address = 1'b0;
    be      = 4'h0;
    data_in = '0;
    rx_drv  = 1'b1;
    loop_en = 1'b0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    reset_and_id();
    transmit_path();
    receive_path();
    overrun_flag();
    framing_error();
    loopback_bytes();
    $display("TEST OK");
    $finish;
  end

endmodule

/* uart.f */
+incdir+design
design/uart_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_regs.sv
design/uart_periph.sv
tb/uart_tb.sv

/* Bender.yml */
package:
  name: uart

sources:
  - include_dirs:
      - design
    files:
      - design/uart_pkg.sv
      - design/uart_tx.sv
      - design/uart_rx.sv
      - design/uart_regs.sv
      - design/uart_periph.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/uart_tb.sv
